// File: bench/fraise_chk.sv
// array control and bus readiness assertions, bound into reg_bank and inference_seq
// inputs that an instance does not see are tied off at the bind
`timescale 1ns/100ps
`default_nettype none

module fraise_chk import fraise_pkg::*; (
    input logic        clk_i,
    input logic        counter_read_reset,
    input logic        busy_i,
    input logic        ready_i,
    input array_ctrl_t ctrl_i
);

    // ready drops with busy and stays low for the whole 29-cycle run
    ready_low_busy: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        $fell(ready_i) |-> busy_i ##29 $rose(ready_i))
        else $error("ready_o did not stay low for exactly one 29-cycle run");

    sl_needs_wl: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        ctrl_i.sl |-> ctrl_i.wl)
        else $error("source line high without word line");

    readout_apart: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        !(ctrl_i.read_out && ctrl_i.read_8))  // read pulses end before read-out
        else $error("read_out overlaps read_8");

endmodule

`default_nettype wire

// File: bench/tb_fraise.sv
// testbench for fraise_top, logarithmic inference path only
// the array is modeled here, bit_out_i is random during read-out with a fixed seed
`timescale 1ns/100ps
`default_nettype none

module tb_fraise import fraise_pkg::*; ();

    localparam int RESP_WAIT = 16;
    localparam int RUN_WAIT  = 100;  // a run takes 29 cycles
    localparam int IDLE_WAIT = 40;

    logic                   clk_i = 1'b0;
    logic                   counter_read_reset;
    logic                   req_valid_i;
    bus_req_t               req_i;
    logic                   ready_o;
    logic                   resp_valid_o;
    bus_resp_t              resp_o;
    logic                   irq_o;
    array_ctrl_t            array_ctrl_o;
    array_addr_t            array_addr_o;
    logic [MATRIX_SIZE-1:0] bit_out_i = '0;

    integer                 rand_seed = 32'h9aa1;
    logic [31:0]            rnd;
    logic [MATRIX_SIZE-1:0] readout_q[$];  // bits the DUT samples, oldest first
    array_addr_t            addr_q[$];     // one entry per read_8 cycle
    array_ctrl_t            ctrl_q[$];     // strobes seen with each read_8 cycle
    int                     inf_seen = 0;
    logic [DATA_W-1:0]      obs_col_exp;
    logic [DATA_W-1:0]      obs_row_exp;
    int                     errors = 0;
    int                     checks = 0;
    int                     tests = 0;
    int                     failed = 0;
    int                     errors_at_start = 0;

    always #50 clk_i = ~clk_i;

    fraise_top UUT (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .req_valid_i        (req_valid_i),
        .req_i              (req_i),
        .ready_o            (ready_o),
        .resp_valid_o       (resp_valid_o),
        .resp_o             (resp_o),
        .irq_o              (irq_o),
        .array_ctrl_o       (array_ctrl_o),
        .array_addr_o       (array_addr_o),
        .bit_out_i          (bit_out_i)
    );

    bind reg_bank fraise_chk u_chk_bus (
        .clk_i (clk_i), .counter_read_reset (counter_read_reset),
        .busy_i (busy_i), .ready_i (ready_o), .ctrl_i ('0)
    );
    bind inference_seq fraise_chk u_chk_array (
        .clk_i (clk_i), .counter_read_reset (counter_read_reset),
        .busy_i (busy_o), .ready_i (1'b0), .ctrl_i (array_ctrl_o)
    );

    // array model, new bits each read-out cycle, sampled by the DUT at the next edge
    always @(posedge clk_i) begin
        #1;
        if (array_ctrl_o.read_out) begin
            rnd = $random(rand_seed);
            bit_out_i = rnd[MATRIX_SIZE-1:0];
            readout_q.push_back(rnd[MATRIX_SIZE-1:0]);
        end else begin
            bit_out_i = '0;
        end
        if (array_ctrl_o.read_8) begin
            addr_q.push_back(array_addr_o);
            ctrl_q.push_back(array_ctrl_o);
        end
        if (array_ctrl_o.inference) inf_seen++;
    end

    function automatic array_addr_t expected_addr(input int k, input logic [DATA_W-1:0] col_reg,
                                                  input logic [DATA_W-1:0] row_reg);
        array_addr_t a;
        a.col = {2'(k), 3'b000, col_reg[8*k +: 3]};  // row k, three zeros, column field
        a.row = {2'b00, row_reg[8*k +: 6]};
        return a;
    endfunction

    // strobes in cycle p of a row's four-cycle read pulse
    function automatic array_ctrl_t expected_pulse(input int p);
        array_ctrl_t c;
        c = '0;
        c.sl     = (p == 0);
        c.wl     = (p != 3);
        c.read_8 = 1'b1;
        return c;
    endfunction

    function automatic result_t expected_result();
        result_t r;
        r = '0;
        for (int i = 0; i < readout_q.size() && i < int'(RES_BITS); i++) begin
            for (int k = 0; k < int'(MATRIX_SIZE); k++) begin
                r[k][RES_BITS-1-i] = readout_q[i][k];  // first sample lands in the MSB
            end
        end
        return r;
    endfunction

    task automatic check_resp(input string name, input bus_resp_t got, input bus_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input array_addr_t got, input array_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_ctrl(input string name, input array_ctrl_t got, input array_ctrl_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_result(input string name, input result_t got, input result_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    // called 1 ns after an edge, returns at the same point of a later cycle
    task automatic bus_access(input logic [HOST_W-1:0] host, input logic [ADDR_W-1:0] addr,
                              input logic wen, input logic [DATA_W-1:0] wdata,
                              input logic [BEN_W-1:0] ben, output bus_resp_t resp);
        int waited;
        waited = 0;
        resp = '0;
        while (!ready_o && waited < RUN_WAIT) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (!ready_o) begin
            errors++;
            $display("timeout: ready_o stayed low, request to 0x%h not sent", addr);
        end else begin
            req_valid_i = 1'b1;
            req_i = '{host: host, addr: addr, wen: wen, wdata: wdata, ben: ben};
            @(posedge clk_i);  // accepted here
            #1;
            req_valid_i = 1'b0;
            req_i = '0;
            waited = 1;
            while (!resp_valid_o && waited < RESP_WAIT) begin
                @(posedge clk_i);
                #1;
                waited++;
            end
            resp = resp_o;
            if (!resp_valid_o) begin
                errors++;
                $display("timeout: no response to the request at 0x%h", addr);
            end else if (waited != 1) begin
                errors++;
                $display("response to 0x%h came %0d cycles after acceptance", addr, waited);
            end
        end
    endtask

    task automatic write_reg(input logic [HOST_W-1:0] host, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input logic [BEN_W-1:0] ben);
        bus_resp_t resp;
        bus_access(host, addr, 1'b1, wdata, ben, resp);
        check_resp("resp_o", resp, '{host: host, rdata: '0});  // writes answer zero
    endtask

    task automatic read_reg(input logic [HOST_W-1:0] host, input logic [ADDR_W-1:0] addr,
                            output bus_resp_t resp);
        bus_access(host, addr, 1'b0, '0, '0, resp);
    endtask

    task automatic wait_irq(input int limit);
        int cycles;
        cycles = 0;
        while (!irq_o && cycles < limit) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (!irq_o) begin
            errors++;
            $display("timeout: irq_o did not rise within %0d cycles", limit);
        end
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: failed", tests, name);
        end
    endtask

    initial begin
        bus_resp_t resp;
        int        cycles;
        int        strobes;
        counter_read_reset = 1'b1;
        req_valid_i = 1'b0;
        req_i = '0;
        obs_col_exp = '0;
        obs_row_exp = '0;
        repeat (10) @(posedge clk_i);
        #1;
        counter_read_reset = 1'b0;

        begin_test();
        check_level("ready_o", ready_o, 1'b1);
        check_level("irq_o", irq_o, 1'b0);
        check_level("array_ctrl_o", |array_ctrl_o, 1'b0);
        read_reg(1'b0, REG_ON_OFF, resp);
        check_resp("resp_o", resp, '{host: 1'b0, rdata: '0});
        end_test("reset state");

        // only the enabled byte lanes are stored
        begin_test();
        write_reg(1'b1, REG_OBS_COL, 32'hffff_ffff, 4'b0101);
        obs_col_exp = 32'h00ff_00ff;
        read_reg(1'b1, REG_OBS_COL, resp);
        check_resp("resp_o", resp, '{host: 1'b1, rdata: obs_col_exp});
        write_reg(1'b0, REG_OBS_ROW, 32'h1234_5678, 4'b1010);
        obs_row_exp = 32'h1200_5600;
        read_reg(1'b1, REG_OBS_ROW, resp);
        check_resp("resp_o", resp, '{host: 1'b1, rdata: obs_row_exp});
        end_test("byte enables and host id");

        begin_test();
        write_reg(1'b0, REG_OBS_COL, 32'h0503_0601, 4'hf);
        obs_col_exp = 32'h0503_0601;
        write_reg(1'b0, REG_OBS_ROW, 32'h2a15_3f07, 4'hf);
        obs_row_exp = 32'h2a15_3f07;
        write_reg(1'b1, REG_ON_OFF, 32'h1, 4'hf);
        write_reg(1'b1, REG_LAUNCH, 32'h1, 4'hf);
        wait_irq(RUN_WAIT);
        if (addr_q.size() != 4 * MATRIX_SIZE) begin
            errors++;
            $display("saw %0d read pulse cycles instead of 16", addr_q.size());
        end
        foreach (addr_q[i]) begin
            if (i < 16) begin
                check_addr("array_addr_o", addr_q[i],
                           expected_addr(i / 4, obs_col_exp, obs_row_exp));
                check_ctrl("array_ctrl_o", ctrl_q[i], expected_pulse(i % 4));
            end
        end
        if (inf_seen != INF_CYCLES) begin
            errors++;
            $display("saw %0d inference cycles instead of 4", inf_seen);
        end
        end_test("read pulse addresses");

        begin_test();
        check_level("irq_o", irq_o, 1'b1);
        if (readout_q.size() != RES_BITS) begin
            errors++;
            $display("saw %0d read-out cycles instead of 8", readout_q.size());
        end
        read_reg(1'b0, REG_RESULT, resp);
        check_result("result", result_t'(resp.rdata), expected_result());
        check_level("irq_o", irq_o, 1'b0);
        read_reg(1'b0, REG_ON_OFF, resp);
        check_resp("resp_o", resp, '{host: 1'b0, rdata: '0});
        end_test("likelihood bytes and irq");

        // on/off is clear after the run, so this launch must do nothing
        begin_test();
        write_reg(1'b1, REG_LAUNCH, 32'h1, 4'hf);
        strobes = 0;
        cycles = 0;
        while (!irq_o && cycles < IDLE_WAIT) begin
            if (array_ctrl_o != '0) strobes++;
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (irq_o) begin
            errors++;
            $display("irq_o rose after a launch with on/off clear");
        end
        if (strobes != 0) begin
            errors++;
            $display("array strobes active in %0d cycles after a launch with on/off clear",
                     strobes);
        end
        check_level("ready_o", ready_o, 1'b1);
        end_test("launch while off");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: common/fraise_pkg.sv
// register offsets follow the host driver map, 32-bit word access only
// array addressing assumes a 4x4 matrix with 8-bit column and row addresses
`default_nettype none

package fraise_pkg;

    localparam int unsigned DATA_W       = 32;
    localparam int unsigned ADDR_W       = 32;
    localparam int unsigned HOST_W       = 1;
    localparam int unsigned MATRIX_SIZE  = 4;
    localparam int unsigned ARRAY_ADDR_W = 8;
    localparam int unsigned OBS_COL_W    = 3;
    localparam int unsigned OBS_ROW_W    = 6;
    localparam int unsigned RES_BITS     = 8;
    localparam int unsigned INF_CYCLES   = 4;

    // derived widths
    localparam int unsigned BEN_W     = DATA_W / 8;
    localparam int unsigned ROW_IDX_W = $clog2(MATRIX_SIZE);
    localparam int unsigned PHASE_W   = $clog2(RES_BITS);  // also covers the inference count
    localparam int unsigned COL_PAD_W = ARRAY_ADDR_W - ROW_IDX_W - OBS_COL_W;
    localparam int unsigned ROW_PAD_W = ARRAY_ADDR_W - OBS_ROW_W;

    // register byte addresses
    localparam logic [ADDR_W-1:0] REG_BASE    = 32'h0000_0010;
    localparam logic [ADDR_W-1:0] REG_ON_OFF  = REG_BASE + 32'h00;
    localparam logic [ADDR_W-1:0] REG_LAUNCH  = REG_BASE + 32'h14;
    localparam logic [ADDR_W-1:0] REG_RESULT  = REG_BASE + 32'h20;  // log likelihoods
    localparam logic [ADDR_W-1:0] REG_OBS_COL = REG_BASE + 32'h24;
    localparam logic [ADDR_W-1:0] REG_OBS_ROW = REG_BASE + 32'h28;

    typedef struct packed {
        logic [HOST_W-1:0] host;
        logic [ADDR_W-1:0] addr;
        logic              wen;    // 1 for write
        logic [DATA_W-1:0] wdata;
        logic [BEN_W-1:0]  ben;
    } bus_req_t;

    typedef struct packed {
        logic [HOST_W-1:0] host;   // echoes the requester
        logic [DATA_W-1:0] rdata;
    } bus_resp_t;

    typedef struct packed {
        logic [MATRIX_SIZE-1:0][OBS_COL_W-1:0] col;
        logic [MATRIX_SIZE-1:0][OBS_ROW_W-1:0] row;
    } obs_vec_t;

    typedef struct packed {
        logic [ARRAY_ADDR_W-1:0] col;
        logic [ARRAY_ADDR_W-1:0] row;
    } array_addr_t;

    typedef struct packed {
        logic sl;
        logic wl;
        logic read_8;
        logic inference;
        logic read_out;
    } array_ctrl_t;

    // one likelihood byte per matrix row, row 0 in the low byte
    typedef logic [MATRIX_SIZE-1:0][RES_BITS-1:0] result_t;

endpackage

`default_nettype wire

// File: inference/inference_seq.sv
// fixed-length log inference run, 29 cycles from start to done
// array address is held on the current row's fields, also while idle
`timescale 1ns/100ps
`default_nettype none

module inference_seq import fraise_pkg::*; (
    input  logic                   clk_i,
    input  logic                   counter_read_reset,
    input  logic                   start_i,
    input  obs_vec_t               obs_i,
    output logic                   busy_o,
    output logic                   done_o,
    output result_t                result_o,
    output array_ctrl_t            array_ctrl_o,
    output array_addr_t            array_addr_o,
    input  logic [MATRIX_SIZE-1:0] bit_out_i
);

    typedef enum logic [2:0] {
        IDLE,
        READ_CYC,
        INF_CYC,
        READ_OUT,
        DONE
    } seq_state_e;

    seq_state_e           state_q;
    logic [ROW_IDX_W-1:0] row_q;    // matrix row being read
    logic [PHASE_W-1:0]   phase_q;  // inference and read-out count
    logic                 in_read;
    logic                 in_readout;
    logic                 pulse_sl;
    logic                 pulse_wl;
    logic                 pulse_last;

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            state_q <= IDLE;
            row_q   <= '0;
            phase_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= READ_CYC;
                        row_q   <= '0;
                    end
                end
                READ_CYC: begin
                    if (pulse_last) begin
                        row_q <= row_q + 1'b1;  // wraps back to row 0
                        if (row_q == ROW_IDX_W'(MATRIX_SIZE - 1)) begin
                            state_q <= INF_CYC;
                            phase_q <= '0;
                        end
                    end
                end
                INF_CYC: begin
                    phase_q <= phase_q + 1'b1;
                    if (phase_q == PHASE_W'(INF_CYCLES - 1)) begin
                        state_q <= READ_OUT;
                        phase_q <= '0;
                    end
                end
                READ_OUT: begin
                    phase_q <= phase_q + 1'b1;
                    if (phase_q == PHASE_W'(RES_BITS - 1)) state_q <= DONE;
                end
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    assign in_read    = (state_q == READ_CYC);
    assign in_readout = (state_q == READ_OUT);
    assign busy_o     = (state_q != IDLE);
    assign done_o     = (state_q == DONE);

    assign array_ctrl_o = '{sl:        pulse_sl,
                            wl:        pulse_wl,
                            read_8:    in_read,
                            inference: (state_q == INF_CYC),
                            read_out:  in_readout};

    // col = {row, pad, col field}, row = {pad, row field}
    assign array_addr_o.col = {row_q, {COL_PAD_W{1'b0}}, obs_i.col[row_q]};
    assign array_addr_o.row = {{ROW_PAD_W{1'b0}}, obs_i.row[row_q]};

    read_pulse_gen u_read_pulse_gen (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .go_i               (in_read),
        .sl_o               (pulse_sl),
        .wl_o               (pulse_wl),
        .last_o             (pulse_last)
    );

    log_result_collector u_log_result_collector (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .clear_i            (start_i),
        .sample_i           (in_readout),
        .bit_out_i          (bit_out_i),
        .result_o           (result_o)
    );

endmodule

`default_nettype wire

// File: inference/log_result_collector.sv
// one shift register per row, first sampled bit ends up as the MSB
// clear_i must come before the first sample of a run
`timescale 1ns/100ps
`default_nettype none

module log_result_collector import fraise_pkg::*; (
    input  logic                   clk_i,
    input  logic                   counter_read_reset,
    input  logic                   clear_i,
    input  logic                   sample_i,
    input  logic [MATRIX_SIZE-1:0] bit_out_i,
    output result_t                result_o
);

    always_ff @(posedge clk_i) begin
        if (counter_read_reset || clear_i) begin
            result_o <= '0;
        end else if (sample_i) begin
            for (int k = 0; k < MATRIX_SIZE; k++) begin
                // shift left, new bit in at the LSB
                result_o[k] <= {result_o[k][RES_BITS-2:0], bit_out_i[k]};
            end
        end
    end

endmodule

`default_nettype wire

// File: inference/read_pulse_gen.sv
// four-phase SL/WL read pulse, advances only while go_i is high
`timescale 1ns/100ps
`default_nettype none

module read_pulse_gen (
    input  logic clk_i,
    input  logic counter_read_reset,
    input  logic go_i,
    output logic sl_o,
    output logic wl_o,
    output logic last_o
);

    typedef enum logic [1:0] {
        SL_WL_RISE,
        SL_FALL,
        WL_HIGH,
        WL_FALL
    } pulse_state_e;

    pulse_state_e state_q;

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            state_q <= SL_WL_RISE;
        end else if (go_i) begin
            case (state_q)
                SL_WL_RISE: state_q <= SL_FALL;
                SL_FALL:    state_q <= WL_HIGH;
                WL_HIGH:    state_q <= WL_FALL;
                default:    state_q <= SL_WL_RISE;  // ready for the next row
            endcase
        end
    end

    assign sl_o   = go_i && (state_q == SL_WL_RISE);
    assign wl_o   = go_i && (state_q != WL_FALL);
    assign last_o = go_i && (state_q == WL_FALL);

endmodule

`default_nettype wire

// File: rtl/fraise_top.sv
// log inference controller for the 4x4 bayesian array, logarithmic mode only
// the array sits outside, its per-row output bits come back on bit_out_i
`timescale 1ns/100ps
`default_nettype none

module fraise_top import fraise_pkg::*; (
    input  logic                   clk_i,
    input  logic                   counter_read_reset,
    input  logic                   req_valid_i,
    input  bus_req_t               req_i,
    output logic                   ready_o,
    output logic                   resp_valid_o,
    output bus_resp_t              resp_o,
    output logic                   irq_o,
    output array_ctrl_t            array_ctrl_o,
    output array_addr_t            array_addr_o,
    input  logic [MATRIX_SIZE-1:0] bit_out_i
);

    obs_vec_t obs;
    logic     start;
    logic     busy;
    logic     done;
    result_t  result;

    reg_bank u_reg_bank (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .req_valid_i        (req_valid_i),
        .req_i              (req_i),
        .ready_o            (ready_o),
        .resp_valid_o       (resp_valid_o),
        .resp_o             (resp_o),
        .irq_o              (irq_o),
        .obs_o              (obs),
        .start_o            (start),
        .busy_i             (busy),
        .done_i             (done),
        .result_i           (result)
    );

    inference_seq u_inference_seq (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .start_i            (start),
        .obs_i              (obs),
        .busy_o             (busy),
        .done_o             (done),
        .result_o           (result),
        .array_ctrl_o       (array_ctrl_o),
        .array_addr_o       (array_addr_o),
        .bit_out_i          (bit_out_i)
    );

endmodule

`default_nettype wire

// File: rtl/reg_bank.sv
// bus slave, response always one cycle after acceptance, no back-pressure
// unmapped addresses read zero, byte enables only mask the observation registers
`timescale 1ns/100ps
`default_nettype none

module reg_bank import fraise_pkg::*; (
    input  logic      clk_i,
    input  logic      counter_read_reset,
    input  logic      req_valid_i,
    input  bus_req_t  req_i,
    output logic      ready_o,
    output logic      resp_valid_o,
    output bus_resp_t resp_o,
    output logic      irq_o,
    output obs_vec_t  obs_o,
    output logic      start_o,
    input  logic      busy_i,
    input  logic      done_i,
    input  result_t   result_i
);

    logic              accept;
    logic              wr_acc;
    logic [DATA_W-1:0] ben_mask;
    logic [DATA_W-1:0] rd_data;
    logic              on_off_q;
    logic              launch_q;
    logic [DATA_W-1:0] obs_col_q;
    logic [DATA_W-1:0] obs_row_q;
    result_t           result_q;

    assign ready_o = ~busy_i;  // no new request while the array runs
    assign accept  = req_valid_i & ready_o;
    assign wr_acc  = accept & req_i.wen;

    // widen byte enables to a bit mask
    always_comb begin
        for (int b = 0; b < BEN_W; b++) begin
            ben_mask[8*b +: 8] = {8{req_i.ben[b]}};
        end
    end

    always_comb begin
        case (req_i.addr)
            REG_ON_OFF:  rd_data = {{(DATA_W-1){1'b0}}, on_off_q};
            REG_LAUNCH:  rd_data = {{(DATA_W-1){1'b0}}, launch_q};
            REG_RESULT:  rd_data = result_q;
            REG_OBS_COL: rd_data = obs_col_q;
            REG_OBS_ROW: rd_data = obs_row_q;
            default:     rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            resp_o.host  <= req_i.host;
            resp_o.rdata <= req_i.wen ? '0 : rd_data;  // writes answer zero
        end
    end

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            on_off_q  <= 1'b0;
            launch_q  <= 1'b0;
            start_o   <= 1'b0;
            irq_o     <= 1'b0;
            obs_col_q <= '0;
            obs_row_q <= '0;
        end else begin
            // accept implies the sequencer is idle, start_o blocks a double launch
            start_o <= wr_acc && (req_i.addr == REG_LAUNCH) && req_i.wdata[0]
                       && on_off_q && !start_o;

            if (done_i) begin
                on_off_q <= 1'b0;  // one shot per launch
            end else if (wr_acc && req_i.addr == REG_ON_OFF) begin
                on_off_q <= req_i.wdata[0];
            end

            if (wr_acc && req_i.addr == REG_LAUNCH) begin
                launch_q <= req_i.wdata[0];
            end else if (start_o) begin
                launch_q <= 1'b0;
            end

            if (wr_acc && req_i.addr == REG_OBS_COL) begin
                obs_col_q <= req_i.wdata & ben_mask;
            end
            if (wr_acc && req_i.addr == REG_OBS_ROW) begin
                obs_row_q <= req_i.wdata & ben_mask;
            end

            // set wins over a same-cycle read
            if (done_i) begin
                irq_o <= 1'b1;
            end else if (accept && !req_i.wen && req_i.addr == REG_RESULT) begin
                irq_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (done_i) begin
            result_q <= result_i;
        end
    end

    // one observation field per byte lane
    always_comb begin
        for (int k = 0; k < MATRIX_SIZE; k++) begin
            obs_o.col[k] = obs_col_q[8*k +: OBS_COL_W];
            obs_o.row[k] = obs_row_q[8*k +: OBS_ROW_W];
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile and run the fraise testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_fraise -f src.f \
    --Mdir obj_dir -o tb_fraise_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_fraise_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
    exit 0
fi
exit 1

// File: src.f
common/fraise_pkg.sv
inference/read_pulse_gen.sv
inference/log_result_collector.sv
inference/inference_seq.sv
rtl/reg_bank.sv
rtl/fraise_top.sv
bench/fraise_chk.sv
bench/tb_fraise.sv
